/* source/cart_bus_pkg.sv */
package cart_bus_pkg;

    ////////////////////
    // Console address windows

    localparam logic [15:0] ROM_LO_END   = 16'h3FFF; // Fixed bank 0 ends here
    localparam logic [15:0] ROM_HI_END   = 16'h7FFF; // Switched bank ends here
    localparam logic [15:0] RAM_WIN_BASE = 16'hA000; // Save RAM window start
    localparam logic [15:0] RAM_WIN_END  = 16'hBFFF;

    // Offset bits inside one window page
    localparam int ROM_PAGE_BITS = 14; // 16 KB ROM page
    localparam int RAM_PAGE_BITS = 13; // 8 KB RAM page

    ////////////////////
    // Register write values

    localparam logic [3:0] RAM_EN_KEY     = 4'hA;  // Low nibble that unlocks RAM
    localparam logic [8:0] ROM_BANK_RESET = 9'd1;  // Switched window starts on bank 1

    // One sample of the console bus pins
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  data;
        logic        rd;   // Level read strobe
        logic        wr;   // Level write strobe
    } vb_bus_t;

endpackage

/* source/cart_mem_pkg.sv */
package cart_mem_pkg;

    ////////////////////
    // Mapper register widths, also the board pin widths

    localparam int ROM_BANK_BITS = 9;
    localparam int RAM_BANK_BITS = 4;

    ////////////////////
    // Shared array geometry

    localparam int MEM_ADDR_BITS = 16; // 64 KB array

    localparam logic [MEM_ADDR_BITS-1:0] ROM_BASE  = 16'h0000; // ROM image, lower half
    localparam logic [MEM_ADDR_BITS-1:0] SRAM_BASE = 16'h8000; // Save RAM, upper half

    // Banked offset bits that land in each region
    localparam int ROM_ADDR_BITS  = 15; // 2 banks of 16 KB
    localparam int SRAM_ADDR_BITS = 15; // 4 banks of 8 KB

    // One physical access to the array
    typedef struct packed {
        logic                     valid;
        logic                     we;    // 1 = write, 0 = read
        logic [MEM_ADDR_BITS-1:0] addr;
        logic [7:0]               wdata;
    } mem_req_t;

endpackage

/* source/mbc5_mapper.sv */
`timescale 1ns/1ps

module mbc5_mapper (
    input  logic                                  vb_clk,
    input  logic                                  vb_rst,
    input  cart_bus_pkg::vb_bus_t                 bus,
    output logic [cart_mem_pkg::ROM_BANK_BITS-1:0] rom_a,
    output logic [cart_mem_pkg::RAM_BANK_BITS-1:0] ram_a,
    output logic                                  rom_cs_n,
    output logic                                  ram_cs_n,
    output cart_mem_pkg::mem_req_t                game_req
);

    ////////////////////
    // Window decode

    logic in_rom;    // 0000-7FFF
    logic in_rom_lo; // 0000-3FFF, always bank 0
    logic in_ram;    // A000-BFFF

    assign in_rom    = bus.addr <= cart_bus_pkg::ROM_HI_END;
    assign in_rom_lo = bus.addr <= cart_bus_pkg::ROM_LO_END;
    assign in_ram    = (bus.addr >= cart_bus_pkg::RAM_WIN_BASE) &&
                       (bus.addr <= cart_bus_pkg::RAM_WIN_END);

    ////////////////////
    // Bank registers

    logic [cart_mem_pkg::ROM_BANK_BITS-1:0] rom_bank;
    logic [cart_mem_pkg::RAM_BANK_BITS-1:0] ram_bank;
    logic                                   ram_en;
    logic                                   wr_last; // Strobe one cycle back
    logic                                   wr_rise;

    assign wr_rise = bus.wr & ~wr_last; // Single-cycle edge pulse

    always_ff @(posedge vb_clk or posedge vb_rst) begin
        if (vb_rst) begin
            wr_last  <= 1'b0;
            rom_bank <= cart_bus_pkg::ROM_BANK_RESET;
            ram_bank <= '0;
            ram_en   <= 1'b0;
        end else begin
            wr_last <= bus.wr;
            if (wr_rise) begin
                // Register picked by upper nibble
                case (bus.addr[15:12])
                    4'h0, 4'h1: ram_en <= (bus.data[3:0] == cart_bus_pkg::RAM_EN_KEY);
                    4'h2:       rom_bank[7:0] <= bus.data;    // Bank low byte
                    4'h3:       rom_bank[8] <= bus.data[0];   // Bank bit 8
                    4'h4, 4'h5: ram_bank <= bus.data[3:0];
                    default: ;                                // RAM window or unmapped
                endcase
            end
        end
    end

    ////////////////////
    // Board pins

    assign rom_a = in_rom_lo ? '0 : rom_bank; // Bank 0 allowed in upper window
    assign ram_a = ram_bank;

    // Selects follow live accesses, held off in reset
    assign rom_cs_n = ~(in_rom & bus.rd & ~vb_rst);
    assign ram_cs_n = ~(in_ram & ram_en & (bus.rd | bus.wr) & ~vb_rst);

    ////////////////////
    // Physical translation

    logic [cart_mem_pkg::ROM_BANK_BITS+cart_bus_pkg::ROM_PAGE_BITS-1:0] rom_off;
    logic [cart_mem_pkg::RAM_BANK_BITS+cart_bus_pkg::RAM_PAGE_BITS-1:0] ram_off;
    logic [cart_mem_pkg::MEM_ADDR_BITS-1:0]                            rom_phys;
    logic [cart_mem_pkg::MEM_ADDR_BITS-1:0]                            ram_phys;
    logic                                                              rd_hit;
    logic                                                              wr_hit;

    assign rom_off = {rom_a, bus.addr[cart_bus_pkg::ROM_PAGE_BITS-1:0]};
    assign ram_off = {ram_a, bus.addr[cart_bus_pkg::RAM_PAGE_BITS-1:0]};

    // Only the low offset bits fit the array
    assign rom_phys = cart_mem_pkg::ROM_BASE +
        {{(cart_mem_pkg::MEM_ADDR_BITS-cart_mem_pkg::ROM_ADDR_BITS){1'b0}},
         rom_off[cart_mem_pkg::ROM_ADDR_BITS-1:0]};
    assign ram_phys = cart_mem_pkg::SRAM_BASE +
        {{(cart_mem_pkg::MEM_ADDR_BITS-cart_mem_pkg::SRAM_ADDR_BITS){1'b0}},
         ram_off[cart_mem_pkg::SRAM_ADDR_BITS-1:0]};

    assign rd_hit = bus.rd & (in_rom | (in_ram & ram_en)); // Level, every cycle
    assign wr_hit = wr_rise & in_ram & ram_en;             // ROM writes hit registers only

    always_comb begin
        game_req.valid = rd_hit | wr_hit;
        game_req.we    = wr_hit;
        game_req.addr  = in_ram ? ram_phys : rom_phys;
        game_req.wdata = bus.data;
    end

endmodule

/* source/cart_mem_arbiter.sv */
`timescale 1ns/1ps

module cart_mem_arbiter (
    input  logic                   vb_clk,
    input  logic                   vb_rst,
    input  cart_mem_pkg::mem_req_t game_req,
    input  logic                   host_req,
    input  logic                   host_we,
    input  logic [15:0]            host_addr,
    input  logic [7:0]             host_wdata,
    output logic                   host_ack,
    output logic [7:0]             host_rdata,
    output logic [7:0]             vb_rdata,
    output cart_mem_pkg::mem_req_t mem_req,
    input  logic [7:0]             mem_rdata
);

    ////////////////////
    // Grant

    logic owner_host_q; // Host held the port last cycle
    logic rd_q;         // Last access was a read
    logic host_grant;

    // Console first, host only in idle cycles, never twice on one request
    assign host_grant = host_req & ~game_req.valid & ~owner_host_q;

    always_comb begin
        mem_req = game_req; // Idle cycles pass valid low
        if (host_grant) begin
            mem_req.valid = 1'b1;
            mem_req.we    = host_we;
            mem_req.addr  = host_addr;
            mem_req.wdata = host_wdata;
        end
    end

    ////////////////////
    // Owner tracking

    always_ff @(posedge vb_clk or posedge vb_rst) begin
        if (vb_rst) begin
            owner_host_q <= 1'b0;
            rd_q         <= 1'b0;
        end else begin
            owner_host_q <= host_grant;
            rd_q         <= mem_req.valid & ~mem_req.we;
        end
    end

    assign host_ack = owner_host_q; // One-cycle pulse per grant

    ////////////////////
    // Read data return

    // Console sees the array straight through, open bus reads FF
    assign vb_rdata = (rd_q & ~owner_host_q) ? mem_rdata : 8'hFF;

    // Host byte captured during ack, held until next host read
    always_ff @(posedge vb_clk) begin
        if (rd_q & owner_host_q) begin
            host_rdata <= mem_rdata;
        end
    end

endmodule

/* source/cart_memory.sv */
`timescale 1ns/1ps

module cart_memory (
    input  logic                   vb_clk,
    input  cart_mem_pkg::mem_req_t req,
    output logic [7:0]             rdata
);

    ////////////////////
    // Byte array

    // ROM image in the low half, save RAM in the high half
    logic [7:0] mem_array [2**cart_mem_pkg::MEM_ADDR_BITS];

    always_ff @(posedge vb_clk) begin
        if (req.valid) begin
            if (req.we) begin
                mem_array[req.addr] <= req.wdata;
            end else begin
                rdata <= mem_array[req.addr]; // Valid next cycle
            end
        end
    end

endmodule

/* source/cart_top.sv */
`timescale 1ns/1ps

module cart_top (
    input  logic        vb_clk,
    input  logic        vb_rst,
    input  logic [15:0] vb_a,
    input  logic [7:0]  vb_d,
    input  logic        vb_rd,
    input  logic        vb_wr,
    output logic [7:0]  vb_rdata,
    input  logic        host_req,
    input  logic        host_we,
    input  logic [15:0] host_addr,
    input  logic [7:0]  host_wdata,
    output logic        host_ack,
    output logic [7:0]  host_rdata,
    output logic [cart_mem_pkg::ROM_BANK_BITS-1:0] rom_a,
    output logic [cart_mem_pkg::RAM_BANK_BITS-1:0] ram_a,
    output logic        rom_cs_n,
    output logic        ram_cs_n
);

    cart_bus_pkg::vb_bus_t  bus;
    cart_mem_pkg::mem_req_t game_req; // Mapper to arbiter
    cart_mem_pkg::mem_req_t mem_req;  // Arbiter to array
    logic [7:0]             mem_rdata;

    // Console pins into one sample
    assign bus = '{addr: vb_a, data: vb_d, rd: vb_rd, wr: vb_wr};

    ////////////////////
    // Mapper, arbiter, array

    mbc5_mapper mapper_i (
        .vb_clk   (vb_clk),
        .vb_rst   (vb_rst),
        .bus      (bus),
        .rom_a    (rom_a),
        .ram_a    (ram_a),
        .rom_cs_n (rom_cs_n),
        .ram_cs_n (ram_cs_n),
        .game_req (game_req)
    );

    cart_mem_arbiter arbiter_i (
        .vb_clk     (vb_clk),
        .vb_rst     (vb_rst),
        .game_req   (game_req),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .vb_rdata   (vb_rdata),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata)
    );

    cart_memory memory_i (
        .vb_clk (vb_clk),
        .req    (mem_req),
        .rdata  (mem_rdata)
    );

endmodule

/* dv/cart_tb.sv */
`timescale 1ns/1ps

module cart_tb;

    localparam int ROM_BYTES     = 32768; // ROM region in the array
    localparam int LOAD_CYCLES   = ROM_BYTES * 8;
    localparam int BANK_CYCLES   = 8 * 40 * 2 + 100;
    localparam int ENABLE_CYCLES = 200;
    localparam int SRAM_CYCLES   = 4 * 8 * 80;
    localparam int WATCHDOG_NS   = (LOAD_CYCLES + BANK_CYCLES + ENABLE_CYCLES + SRAM_CYCLES
                                    + 2000) * 10;

    logic        vb_clk = 1'b0;
    logic        vb_rst;
    logic [15:0] vb_a;
    logic [7:0]  vb_d;
    logic        vb_rd, vb_wr;
    logic [7:0]  vb_rdata;
    logic        host_req, host_we;
    logic [15:0] host_addr;
    logic [7:0]  host_wdata;
    logic        host_ack;
    logic [7:0]  host_rdata;
    logic [8:0]  rom_a;
    logic [3:0]  ram_a;
    logic        rom_cs_n, ram_cs_n;

    int          errors = 0;
    int          host_done = 0; // Acknowledged host accesses
    logic        load_done;

    always #5 vb_clk = ~vb_clk; // 10 ns clock

    cart_top dut_i (.*);

    ////////////////////
    // Shadow model

    logic [8:0]  m_rom_bank;
    logic [3:0]  m_ram_bank;
    logic        m_ram_en;
    logic        m_wr_last;
    logic [7:0]  model_mem [65536]; // Starts X like the array
    logic        rd_pend;           // Console read to check next cycle
    logic [7:0]  rd_exp;
    logic [7:0]  host_rd_exp;
    logic        in_ram_w, con_valid;

    function automatic logic [15:0] rom_phys(input logic [15:0] a, input logic [8:0] bank);
        if (a <= 16'h3FFF) return {2'b00, a[13:0]};   // Fixed bank 0
        return {1'b0, bank[0], a[13:0]};               // Only 2 banks fit
    endfunction

    function automatic logic [15:0] ram_phys(input logic [15:0] a, input logic [3:0] bank);
        return 16'h8000 + {1'b0, bank[1:0], a[12:0]};  // 4 banks of 8 KB
    endfunction

    assign in_ram_w  = (vb_a >= 16'hA000) && (vb_a <= 16'hBFFF);
    assign con_valid = (vb_rd && (vb_a <= 16'h7FFF || (in_ram_w && m_ram_en))) ||
                       (vb_wr && !m_wr_last && in_ram_w && m_ram_en);

    always @(posedge vb_clk or posedge vb_rst) begin
        if (vb_rst) begin
            m_rom_bank <= 9'd1;
            m_ram_bank <= 4'd0;
            m_ram_en   <= 1'b0;
            m_wr_last  <= 1'b0;
            rd_pend    <= 1'b0;
        end else begin
            m_wr_last <= vb_wr;
            if (vb_wr && !m_wr_last) begin
                case (vb_a[15:12]) // Registers by upper nibble
                    4'h0, 4'h1: m_ram_en <= (vb_d[3:0] == 4'hA);
                    4'h2: m_rom_bank[7:0] <= vb_d;
                    4'h3: m_rom_bank[8] <= vb_d[0];
                    4'h4, 4'h5: m_ram_bank <= vb_d[3:0];
                    default: begin
                        if (in_ram_w && m_ram_en) begin
                            model_mem[ram_phys(vb_a, m_ram_bank)] = vb_d;
                        end
                    end
                endcase
            end
            // Data only checked where the bank lands in the array
            rd_pend <= vb_rd && (vb_a <= 16'h3FFF ||
                       (vb_a <= 16'h7FFF && m_rom_bank < 9'd2) || (in_ram_w && m_ram_en));
            rd_exp  <= in_ram_w ? model_mem[ram_phys(vb_a, m_ram_bank)]
                                : model_mem[rom_phys(vb_a, m_rom_bank)];
        end
    end

    ////////////////////
    // Assertions

    a_reset_pins: assert property (@(posedge vb_clk) vb_rst |-> rom_cs_n && ram_cs_n && !host_ack)
        else begin
            errors++;
            $display("FAILED reset_pins expected %b actual %b", 3'b110,
                     $sampled({rom_cs_n, ram_cs_n, host_ack}));
        end
    a_rom_a: assert property (@(posedge vb_clk) disable iff (vb_rst)
        rom_a == ((vb_a <= 16'h3FFF) ? 9'd0 : m_rom_bank))
        else begin
            errors++;
            $display("FAILED rom_a expected %h actual %h", $sampled((vb_a <= 16'h3FFF) ? 9'd0
                     : m_rom_bank), $sampled(rom_a));
        end
    a_ram_a: assert property (@(posedge vb_clk) disable iff (vb_rst) ram_a == m_ram_bank)
        else begin
            errors++;
            $display("FAILED ram_a expected %h actual %h", $sampled(m_ram_bank), $sampled(ram_a));
        end
    a_rom_cs: assert property (@(posedge vb_clk) disable iff (vb_rst)
        rom_cs_n == !(vb_rd && vb_a <= 16'h7FFF))
        else begin
            errors++;
            $display("FAILED rom_cs_n expected %b actual %b",
                     $sampled(!(vb_rd && vb_a <= 16'h7FFF)), $sampled(rom_cs_n));
        end
    a_ram_cs: assert property (@(posedge vb_clk) disable iff (vb_rst)
        ram_cs_n == !(in_ram_w && m_ram_en && (vb_rd || vb_wr)))
        else begin
            errors++;
            $display("FAILED ram_cs_n expected %b actual %b",
                     $sampled(!(in_ram_w && m_ram_en && (vb_rd || vb_wr))), $sampled(ram_cs_n));
        end
    a_vb_rdata: assert property (@(posedge vb_clk) disable iff (vb_rst)
        rd_pend |-> vb_rdata === rd_exp)
        else begin
            errors++;
            $display("FAILED vb_rdata expected %h actual %h", $sampled(rd_exp), $sampled(vb_rdata));
        end
    a_host_rdata: assert property (@(posedge vb_clk) disable iff (vb_rst)
        (host_ack && !host_we) |=> host_rdata === host_rd_exp)
        else begin
            errors++;
            $display("FAILED host_rdata expected %h actual %h", $sampled(host_rd_exp),
                     $sampled(host_rdata));
        end
    // Grant cycle precedes ack, console must have been idle then
    a_host_gap: assert property (@(posedge vb_clk) disable iff (vb_rst)
        host_ack |-> $past(!con_valid))
        else begin
            errors++;
            $display("Host granted while the console held a request");
        end

    ////////////////////
    // Stimulus helpers

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    // All tasks start and end at a falling edge
    task automatic host_access(input logic we, input logic [15:0] addr, input logic [7:0] data);
        int waited;
        host_we    = we;
        host_addr  = addr;
        host_wdata = data;
        host_req   = 1'b1;
        waited     = 0;
        do begin
            @(negedge vb_clk);
            waited++;
        end while (!host_ack && waited < 64);
        if (!host_ack) begin
            errors++;
            $display("Host access to %h was never acknowledged", addr);
        end else begin
            host_done++;
            if (we) model_mem[addr] = data;
            else host_rd_exp = model_mem[addr];
        end
        host_req = 1'b0;
        @(negedge vb_clk); // Hold address and we through the data cycle
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        vb_a  = addr;
        vb_d  = data;
        vb_wr = 1'b1;
        @(negedge vb_clk);
        vb_wr = 1'b0;
        @(negedge vb_clk);
    endtask

    task automatic bus_read(input logic [15:0] addr);
        vb_a  = addr;
        vb_rd = 1'b1;
        @(negedge vb_clk);
        vb_rd = 1'b0;
    endtask

    task automatic set_rom_bank(input logic [8:0] bank);
        bus_write(16'h2000, bank[7:0]);
        bus_write(16'h3000, {7'd0, bank[8]});
    endtask

    ////////////////////
    // Phases

    initial begin
        logic [31:0] hs, cs;
        logic [8:0]  banks [8];
        logic [15:0] offs [8];
        hs = 32'he1ce;
        cs = 32'he1ce ^ 32'h5a5a_0000;
        banks = '{9'd0, 9'd1, 9'd2, 9'h100, 9'h101, 9'h1FF, 9'h0FE, 9'd1};
        // ROM read held through reset, selects must still stay off
        {vb_rst, vb_a, vb_d, vb_rd, vb_wr} = {1'b1, 16'h0100, 8'h0, 1'b1, 1'b0};
        {host_req, host_we, host_addr, host_wdata, load_done} = '0;
        host_rd_exp = 8'h00;
        repeat (3) @(posedge vb_clk);
        @(negedge vb_clk);
        vb_rst = 1'b0;
        vb_rd  = 1'b0;

        // Reset state of the bank registers
        vb_a = 16'h4000;
        #1;
        if (rom_a !== 9'd1) begin
            errors++;
            $display("FAILED reset_rom_bank expected %h actual %h", 9'd1, rom_a);
        end
        @(negedge vb_clk);
        bus_read(16'hA000); // RAM still disabled

        // Host fills ROM under console reads
        fork
            begin
                for (int i = 0; i < ROM_BYTES; i++) begin
                    hs = xorshift(hs);
                    host_access(1'b1, i[15:0], hs[7:0]);
                end
                load_done = 1'b1;
            end
            begin
                while (!load_done) begin
                    cs    = xorshift(cs);
                    vb_a  = {1'b0, cs[14:0]};
                    vb_rd = cs[16];
                    @(negedge vb_clk);
                end
                vb_rd = 1'b0;
            end
        join
        @(negedge vb_clk);

        // Fixed and switched ROM windows
        foreach (banks[b]) begin
            set_rom_bank(banks[b]);
            repeat (20) begin
                hs = xorshift(hs);
                bus_read({2'b00, hs[13:0]});
                bus_read({2'b01, hs[29:16]});
            end
        end

        // RAM enable key decode
        bus_write(16'h0000, 8'h0A);
        bus_write(16'hA010, 8'h5C);
        bus_write(16'h0000, 8'h0B);
        bus_write(16'hA010, 8'hC5); // Must be dropped
        bus_read(16'hA010);
        bus_write(16'h1FFF, 8'h3A); // Any high nibble with A
        bus_read(16'hA010);
        bus_write(16'h1000, 8'h00);
        bus_write(16'hA010, 8'h77);
        bus_write(16'h0000, 8'h1A);
        bus_read(16'hA010);

        // Banked save RAM, then host readback
        for (int b = 0; b < 4; b++) begin
            bus_write(16'h4000, b[7:0]);
            foreach (offs[k]) begin
                hs = xorshift(hs);
                offs[k] = {3'b000, hs[12:0]};
                bus_write(16'hA000 + offs[k], hs[23:16]);
            end
            foreach (offs[k]) bus_read(16'hA000 + offs[k]);
            foreach (offs[k]) host_access(1'b0, 16'h8000 + b * 16'h2000 + offs[k], 8'h00);
        end

        repeat (4) @(negedge vb_clk);
        $display("Errors: %0d, host accesses acknowledged: %0d", errors, host_done);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all phases completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* tb.f */
source/cart_bus_pkg.sv
source/cart_mem_pkg.sv
source/mbc5_mapper.sv
source/cart_mem_arbiter.sv
source/cart_memory.sv
source/cart_top.sv
dv/cart_tb.sv

/* Bender.yml */
package:
  name: cart_mbc5

dependencies: {}

sources:
  - files:
      - source/cart_bus_pkg.sv
      - source/cart_mem_pkg.sv
      - source/mbc5_mapper.sv
      - source/cart_mem_arbiter.sv
      - source/cart_memory.sv
      - source/cart_top.sv
  - target: test
    files:
      - dv/cart_tb.sv
